// ==== hw/spi_pkg.sv ====
/*
 * Shared sizes, register map and payload types of the SPI controller.
 * Sizes are fixed here; the FIFO depth must stay a power of two.
 */
package spi_pkg;

    localparam int SPI_DATA_WIDTH = 8;
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_PTR_WIDTH = 4;   // log2 of FIFO_DEPTH
    localparam int DIV_WIDTH      = 8;
    localparam int REG_ADDR_WIDTH = 3;
    localparam int BUS_DATA_WIDTH = 32;

    // Register map
    localparam logic [REG_ADDR_WIDTH-1:0] CONTROL_ADDR = 3'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] CLK_DIV_ADDR = 3'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] TX_DATA_ADDR = 3'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] RX_DATA_ADDR = 3'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] STATUS_ADDR  = 3'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] PARAM_ADDR   = 3'd5;

    typedef struct packed {
        logic                      last;   // Release CS_N after this word
        logic [SPI_DATA_WIDTH-1:0] data;
    } tx_word_t;

    typedef struct packed {
        logic [SPI_DATA_WIDTH-1:0] data;
    } rx_word_t;

    typedef struct packed {
        logic                 cpol;
        logic                 cpha;
        logic [DIV_WIDTH-1:0] clk_div;  // Half period is clk_div + 1 clocks
    } spi_cfg_t;

    typedef struct packed {
        logic                      wr_stb;
        logic                      rd_stb;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [BUS_DATA_WIDTH-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                      rd_valid;
        logic [BUS_DATA_WIDTH-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

endpackage

// ==== hw/spi_fifo.sv ====
/*
 * Single-clock FIFO, FIFO_DEPTH entries of payload_t, head shown combinationally.
 * A push while full or a pop while empty is ignored without notice.
 */
module spi_fifo #(
    parameter type payload_t = spi_pkg::tx_word_t
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);
    import spi_pkg::*;

    payload_t                  mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_PTR_WIDTH:0]   count_q;
    logic                      do_push;
    logic                      do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (FIFO_PTR_WIDTH + 1)'(do_push)
                               - (FIFO_PTR_WIDTH + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o = mem_q[rd_ptr_q];

endmodule

// ==== hw/spi_reg_file.sv ====
/*
 * Register port with single-cycle strobes and no back-pressure.
 * Read data is valid exactly one cycle after rd_stb.
 * Pushes into a full transmit FIFO are lost; nothing reports it.
 */
module spi_reg_file (
    input  logic              clk_i,
    input  logic              rst_i,
    input  spi_pkg::bus_req_t bus_i,
    output spi_pkg::bus_rsp_t bus_o,
    output spi_pkg::spi_cfg_t cfg_o,
    output logic              soft_rst_o,
    output logic              tx_push_o,
    output spi_pkg::tx_word_t tx_word_o,
    output logic              rx_pop_o,
    input  spi_pkg::rx_word_t rx_word_i,
    input  logic              rx_empty_i,
    input  logic              rx_full_i,
    input  logic              tx_empty_i,
    input  logic              tx_full_i,
    input  logic              busy_i
);
    import spi_pkg::*;

    spi_cfg_t                  cfg_q;
    logic                      soft_rst_q;
    logic                      rd_valid_q;
    logic [BUS_DATA_WIDTH-1:0] rdata_q;
    logic [BUS_DATA_WIDTH-1:0] rdata_d;
    logic                      wr_ctrl;
    logic                      wr_div;

    assign wr_ctrl = bus_i.wr_stb && (bus_i.addr == CONTROL_ADDR);
    assign wr_div  = bus_i.wr_stb && (bus_i.addr == CLK_DIV_ADDR);

    // ========================================
    // Write side
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q      <= '{cpol: 1'b0, cpha: 1'b0, clk_div: DIV_WIDTH'(1)};
            soft_rst_q <= 1'b0;
        end else begin
            soft_rst_q <= wr_ctrl && bus_i.wdata[2];
            // Soft reset write leaves the mode bits alone
            if (wr_ctrl && !bus_i.wdata[2]) begin
                cfg_q.cpol <= bus_i.wdata[0];
                cfg_q.cpha <= bus_i.wdata[1];
            end
            if (wr_div) begin
                cfg_q.clk_div <= bus_i.wdata[DIV_WIDTH-1:0];
            end
        end
    end

    assign tx_push_o      = bus_i.wr_stb && (bus_i.addr == TX_DATA_ADDR);
    assign tx_word_o.last = bus_i.wdata[SPI_DATA_WIDTH];
    assign tx_word_o.data = bus_i.wdata[SPI_DATA_WIDTH-1:0];

    // ========================================
    // Read side
    // ========================================
    assign rx_pop_o = bus_i.rd_stb && (bus_i.addr == RX_DATA_ADDR) && !rx_empty_i;

    always_comb begin
        rdata_d = '0;
        case (bus_i.addr)
            CONTROL_ADDR: begin
                rdata_d[0] = cfg_q.cpol;
                rdata_d[1] = cfg_q.cpha;
            end
            CLK_DIV_ADDR: rdata_d[DIV_WIDTH-1:0] = cfg_q.clk_div;
            RX_DATA_ADDR: begin
                if (!rx_empty_i) begin
                    rdata_d[SPI_DATA_WIDTH-1:0] = rx_word_i.data;
                end
            end
            STATUS_ADDR: rdata_d[4:0] = {busy_i, tx_full_i, rx_full_i, tx_empty_i, rx_empty_i};
            PARAM_ADDR: begin
                rdata_d[7:0]  = 8'(SPI_DATA_WIDTH);
                rdata_d[15:8] = 8'(FIFO_DEPTH);
            end
            default: rdata_d = '0;  // TX_DATA is write only
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= bus_i.rd_stb;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.rd_stb) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus_o.rd_valid = rd_valid_q;
    assign bus_o.rdata    = rdata_q;
    assign cfg_o          = cfg_q;
    assign soft_rst_o     = soft_rst_q;

endmodule

// ==== hw/spi_master.sv ====
/*
 * SPI shift engine, MSB first, one chip select, all four CPOL/CPHA modes.
 * Mode and divider are taken when CS_N falls; later changes wait for the next frame.
 * A full receive FIFO drops incoming bytes.
 */
module spi_master (
    input  logic               clk_i,
    input  logic               rst_i,
    input  spi_pkg::spi_cfg_t  cfg_i,
    input  logic               tx_empty_i,
    input  spi_pkg::tx_word_t  tx_word_i,
    output logic               tx_pop_o,
    output logic               rx_push_o,
    output spi_pkg::rx_word_t  rx_word_o,
    output spi_pkg::spi_pins_t spi_o,
    input  logic               miso_i,
    output logic               busy_o
);
    import spi_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,   // CS_N low, waiting for the next word
        ST_SHIFT,
        ST_END     // Half period hold before CS_N rises
    } state_t;

    state_t                                state_q;
    logic                                  cpol_q;
    logic                                  cpha_q;
    logic [DIV_WIDTH-1:0]                  div_q;
    logic [DIV_WIDTH-1:0]                  div_cnt_q;
    logic [$clog2(2*SPI_DATA_WIDTH)-1:0]   edge_cnt_q;
    logic [SPI_DATA_WIDTH-1:0]             tx_sh_q;
    logic [SPI_DATA_WIDTH-1:0]             rx_sh_q;
    logic                                  last_q;
    logic                                  sclk_tgl_q;
    logic                                  cs_n_q;
    logic                                  mosi_q;
    logic                                  rx_push_q;
    logic                                  half_tick;
    logic                                  last_edge;
    logic                                  sample_edge;
    logic                                  shift_edge;
    logic                                  load_pha;

    assign half_tick = (div_cnt_q == div_q);
    assign last_edge = (int'(edge_cnt_q) == 2 * SPI_DATA_WIDTH - 1);

    // Even count is a leading edge
    assign sample_edge = (state_q == ST_SHIFT) && half_tick && (edge_cnt_q[0] == cpha_q);
    assign shift_edge  = (state_q == ST_SHIFT) && half_tick && (edge_cnt_q[0] != cpha_q)
                         && !last_edge;

    assign tx_pop_o = ((state_q == ST_IDLE) || (state_q == ST_LOAD)) && !tx_empty_i;
    assign load_pha = (state_q == ST_IDLE) ? cfg_i.cpha : cpha_q;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            cs_n_q     <= 1'b1;
            mosi_q     <= 1'b0;
            sclk_tgl_q <= 1'b0;
            div_cnt_q  <= '0;
            edge_cnt_q <= '0;
            rx_push_q  <= 1'b0;
        end else begin
            // Eighth sample lands on count 14 or 15
            rx_push_q <= sample_edge && (int'(edge_cnt_q) >= 2 * SPI_DATA_WIDTH - 2);
            case (state_q)
                ST_IDLE, ST_LOAD: begin
                    if (tx_pop_o) begin
                        cs_n_q     <= 1'b0;
                        div_cnt_q  <= '0;
                        edge_cnt_q <= '0;
                        state_q    <= ST_SHIFT;
                        if (!load_pha) mosi_q <= tx_word_i.data[SPI_DATA_WIDTH-1];
                    end
                end
                ST_SHIFT: begin
                    if (half_tick) begin
                        div_cnt_q  <= '0;
                        sclk_tgl_q <= ~sclk_tgl_q;
                        edge_cnt_q <= edge_cnt_q + 1'b1;
                        if (shift_edge) mosi_q <= tx_sh_q[SPI_DATA_WIDTH-1];
                        if (last_edge) state_q <= last_q ? ST_END : ST_LOAD;
                    end else begin
                        div_cnt_q <= div_cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (half_tick) begin
                        div_cnt_q <= '0;
                        cs_n_q    <= 1'b1;
                        state_q   <= ST_IDLE;
                    end else begin
                        div_cnt_q <= div_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // ========================================
    // Shift registers
    // ========================================
    always_ff @(posedge clk_i) begin
        if (tx_pop_o) begin
            last_q  <= tx_word_i.last;
            // cpha 0 already put the MSB on MOSI
            tx_sh_q <= load_pha ? tx_word_i.data
                                : {tx_word_i.data[SPI_DATA_WIDTH-2:0], 1'b0};
            if (state_q == ST_IDLE) begin
                cpol_q <= cfg_i.cpol;
                cpha_q <= cfg_i.cpha;
                div_q  <= cfg_i.clk_div;
            end
        end else if (shift_edge) begin
            tx_sh_q <= tx_sh_q << 1;
        end
        if (sample_edge) begin
            rx_sh_q <= {rx_sh_q[SPI_DATA_WIDTH-2:0], miso_i};
        end
    end

    // Idle SCLK follows the live cpol setting
    always_comb begin
        spi_o.sclk = ((state_q == ST_IDLE) ? cfg_i.cpol : cpol_q) ^ sclk_tgl_q;
        spi_o.cs_n = cs_n_q;
        spi_o.mosi = mosi_q;
    end

    assign rx_push_o      = rx_push_q;
    assign rx_word_o.data = rx_sh_q;
    assign busy_o         = (state_q != ST_IDLE);

endmodule

// ==== hw/spi_ctrl_top.sv ====
/*
 * SPI master controller top: register port, two FIFOs and the shift engine.
 * Soft reset clears FIFOs and engine but keeps the configuration.
 */
module spi_ctrl_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  spi_pkg::bus_req_t  bus_i,
    output spi_pkg::bus_rsp_t  bus_o,
    output spi_pkg::spi_pins_t spi_o,
    input  logic               miso_i
);
    import spi_pkg::*;

    spi_cfg_t cfg;
    tx_word_t tx_wr_word;
    tx_word_t tx_head;
    rx_word_t rx_wr_word;
    rx_word_t rx_head;
    logic     soft_rst;
    logic     core_rst;
    logic     tx_push;
    logic     tx_pop;
    logic     tx_empty;
    logic     tx_full;
    logic     rx_push;
    logic     rx_pop;
    logic     rx_empty;
    logic     rx_full;
    logic     busy;

    assign core_rst = rst_i | soft_rst;  // FIFOs and engine only

    spi_reg_file u_regs (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_i     (bus_i),
        .bus_o     (bus_o),
        .cfg_o     (cfg),
        .soft_rst_o(soft_rst),
        .tx_push_o (tx_push),
        .tx_word_o (tx_wr_word),
        .rx_pop_o  (rx_pop),
        .rx_word_i (rx_head),
        .rx_empty_i(rx_empty),
        .rx_full_i (rx_full),
        .tx_empty_i(tx_empty),
        .tx_full_i (tx_full),
        .busy_i    (busy)
    );

    spi_fifo #(
        .payload_t(tx_word_t)
    ) u_tx_fifo (
        .clk_i  (clk_i),
        .rst_i  (core_rst),
        .push_i (tx_push),
        .data_i (tx_wr_word),
        .pop_i  (tx_pop),
        .data_o (tx_head),
        .empty_o(tx_empty),
        .full_o (tx_full)
    );

    spi_fifo #(
        .payload_t(rx_word_t)
    ) u_rx_fifo (
        .clk_i  (clk_i),
        .rst_i  (core_rst),
        .push_i (rx_push),
        .data_i (rx_wr_word),
        .pop_i  (rx_pop),
        .data_o (rx_head),
        .empty_o(rx_empty),
        .full_o (rx_full)
    );

    spi_master u_master (
        .clk_i     (clk_i),
        .rst_i     (core_rst),
        .cfg_i     (cfg),
        .tx_empty_i(tx_empty),
        .tx_word_i (tx_head),
        .tx_pop_o  (tx_pop),
        .rx_push_o (rx_push),
        .rx_word_o (rx_wr_word),
        .spi_o     (spi_o),
        .miso_i    (miso_i),
        .busy_o    (busy)
    );

endmodule

// ==== include/tb_xorshift.svh ====
/*
 * Xorshift32 generator for stimulus; a zero state stays zero, so seed nonzero.
 */
`ifndef TB_XORSHIFT_SVH
`define TB_XORSHIFT_SVH

localparam logic [31:0] XORSHIFT_SEED = 32'd42;

// Next state, also used directly as the random value
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

// ==== tests/tb_spi_ctrl.sv ====
/*
 * Testbench for the SPI controller: random bursts in all four modes, receive path,
 * FIFO overflow and soft reset. A slave model on the SPI pins records both directions.
 */
module tb_spi_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    import spi_pkg::*;

    `include "tb_xorshift.svh"

    localparam int CLK_PERIOD  = 20;
    localparam int MAX_BURST   = 6;
    localparam int OVF_WRITES  = 20;
    localparam int OVF_DIV     = 40;   // Largest divider used
    localparam int SR_DIV      = 9;
    localparam int SR_BYTES    = 4;
    localparam int WRITE_CLKS  = 2;    // Posedges between back to back bus writes
    localparam int MAX_BYTES   = 4 * MAX_BURST + OVF_WRITES + SR_BYTES;
    localparam int WATCHDOG_NS = MAX_BYTES * 16 * (OVF_DIV + 1) * CLK_PERIOD + 100_000;

    logic        clk;
    logic        rst;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    spi_pins_t   spi;
    logic        miso;
    logic [31:0] rng_state;
    int          errors;
    int          slave_errors;
    int          checks;

    // Slave model state
    logic        exp_cpol;
    logic        exp_cpha;
    logic        frm_cpol;
    logic        frm_cpha;
    logic        prev_cs_n;
    logic        prev_sclk;
    logic        lead;
    logic [7:0]  mosi_sh;
    logic [7:0]  miso_sh;
    logic [7:0]  miso_byte;
    logic [31:0] miso_rng;
    int          bit_cnt;
    int          drv_cnt;
    int          frame_bytes;
    logic [7:0]  mosi_q[$];
    logic [7:0]  miso_q[$];
    int          frame_q[$];
    logic [7:0]  sent_q[$];
    int          mosi_rd;
    int          miso_rd;
    int          frame_rd;
    int          sent_rd;

    spi_ctrl_top dut0 (
        .clk_i (clk),
        .rst_i (rst),
        .bus_i (bus_req),
        .bus_o (bus_rsp),
        .spi_o (spi),
        .miso_i(miso)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT never went idle", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Writes that clear nothing update the mode at the strobe edge
    initial begin : cfg_model
        exp_cpol <= 1'b0;
        exp_cpha <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                exp_cpol <= 1'b0;
                exp_cpha <= 1'b0;
            end else if (bus_req.wr_stb && bus_req.addr == CONTROL_ADDR && !bus_req.wdata[2]) begin
                exp_cpol <= bus_req.wdata[0];
                exp_cpha <= bus_req.wdata[1];
            end
        end
    end

    // ========================================
    // SPI slave model
    // ========================================
    task automatic drive_miso();
        if (drv_cnt == 8) begin
            miso_rng  = xorshift32(miso_rng);
            miso_byte = miso_rng[7:0];
            miso_sh   = miso_rng[7:0];
            drv_cnt   = 0;
        end
        miso    = miso_sh[7];  // MSB first
        miso_sh = {miso_sh[6:0], 1'b0};
        drv_cnt++;
    endtask

    initial begin : spi_slave
        miso      = 1'b0;
        prev_cs_n = 1'b1;
        prev_sclk = 1'b0;
        miso_rng  = ~XORSHIFT_SEED;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (spi.cs_n) begin
                    assert (spi.sclk === exp_cpol) else begin
                        slave_errors++;
                        $display("FAILED sclk_idle: expected %0b, actual %0b", exp_cpol, spi.sclk);
                    end
                    if (!prev_cs_n) frame_q.push_back(frame_bytes);
                end else if (prev_cs_n) begin
                    frm_cpol    = exp_cpol;
                    frm_cpha    = exp_cpha;
                    frame_bytes = 0;
                    bit_cnt     = 0;
                    drv_cnt     = 8;
                    if (!frm_cpha) drive_miso();  // First bit before the first edge
                end else if (spi.sclk !== prev_sclk) begin
                    lead = (spi.sclk !== frm_cpol);
                    if (lead != frm_cpha) begin
                        mosi_sh = {mosi_sh[6:0], spi.mosi};
                        bit_cnt++;
                        if (bit_cnt == 8) begin
                            mosi_q.push_back(mosi_sh);
                            miso_q.push_back(miso_byte);
                            frame_bytes++;
                            bit_cnt = 0;
                        end
                    end else begin
                        drive_miso();
                    end
                end
                prev_cs_n = spi.cs_n;
                prev_sclk = spi.sclk;
            end
        end
    end

    // ========================================
    // Bus tasks and checks
    // ========================================
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic bus_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        bus_req.wr_stb = 1'b1;
        bus_req.addr   = addr;
        bus_req.wdata  = data;
        @(negedge clk);
        bus_req.wr_stb = 1'b0;
    endtask

    task automatic bus_read(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        bus_req.rd_stb = 1'b1;
        bus_req.addr   = addr;
        @(negedge clk);
        bus_req.rd_stb = 1'b0;
        assert (bus_rsp.rd_valid === 1'b1) else begin
            errors++;
            $display("Read of address %0d returned no rd_valid one cycle later", addr);
        end
        data = bus_rsp.rdata;
    endtask

    task automatic read_check(input string name, input logic [REG_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] data;
        bus_read(addr, data);
        check_eq(name, exp, data);
    endtask

    // Idle means tx empty with busy low
    task automatic wait_idle();
        logic [31:0] st;
        st = '0;
        do bus_read(STATUS_ADDR, st); while (!(st[1] && !st[4]));
    endtask

    task automatic check_mosi(input string name, input int n);
        check_eq({name, "_count"}, 32'(n), 32'(mosi_q.size() - mosi_rd));
        for (int i = 0; i < n && mosi_rd < mosi_q.size(); i++) begin
            check_eq(name, 32'(sent_q[sent_rd + i]), 32'(mosi_q[mosi_rd]));
            mosi_rd++;
        end
        sent_rd = sent_q.size();
    endtask

    task automatic check_frames(input int len);
        check_eq("frame_count", 32'd1, 32'(frame_q.size() - frame_rd));
        if (frame_q.size() > frame_rd) check_eq("frame_bytes", 32'(len), 32'(frame_q[frame_rd]));
        frame_rd = frame_q.size();
    endtask

    task automatic check_rx(input string name, input int n);
        logic [31:0] data;
        for (int i = 0; i < n; i++) begin
            bus_read(RX_DATA_ADDR, data);
            if (miso_rd < miso_q.size()) begin
                check_eq(name, 32'(miso_q[miso_rd]), data);
            end else begin
                errors++;
                $display("Receive data read with no matching MISO byte from the slave");
            end
            miso_rd++;
        end
    endtask

    // TX FIFO fill level when writes arrive faster than words leave
    function automatic int accepted_writes(input int n_writes, input int spacing,
                                           input int word_clks);
        int count;
        int accepted;
        int next_pop;
        int push;
        int pop;
        count    = 0;
        accepted = 0;
        next_pop = 1;  // Engine pops one cycle after the first write
        for (int c = 0; c <= (n_writes - 1) * spacing; c++) begin
            push = ((c % spacing == 0) && (count < FIFO_DEPTH)) ? 1 : 0;
            pop  = ((c >= next_pop) && (count > 0)) ? 1 : 0;
            if (pop != 0) next_pop = c + word_clks;
            accepted += push;
            count    += push - pop;
        end
        return accepted;
    endfunction

    // ========================================
    // Test sequence
    // ========================================
    initial begin : main
        logic [31:0] r;
        logic [31:0] st;
        int          div;
        int          len;
        int          n_ok;
        bus_req   = '0;
        rst       = 1'b1;
        rng_state = XORSHIFT_SEED;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_eq("reset_cs_n", 32'd1, 32'(spi.cs_n));
        check_eq("reset_sclk", 32'd0, 32'(spi.sclk));
        check_eq("reset_mosi", 32'd0, 32'(spi.mosi));
        read_check("reset_status", STATUS_ADDR, 32'h3);
        read_check("param", PARAM_ADDR, 32'h0000_1008);  // Depth 16, width 8

        for (int m = 0; m < 4; m++) begin
            r   = next_rand();
            div = int'(r % 32'd8);
            r   = next_rand();
            len = 1 + int'(r % 32'(MAX_BURST));
            bus_write(CONTROL_ADDR, 32'(m));   // bit 0 cpol, bit 1 cpha
            bus_write(CLK_DIV_ADDR, 32'(div));
            for (int i = 0; i < len; i++) begin
                r = next_rand();
                sent_q.push_back(r[7:0]);
                bus_write(TX_DATA_ADDR, {23'd0, i == len - 1, r[7:0]});
            end
            wait_idle();
            check_mosi($sformatf("mode%0d_mosi", m), len);
            check_frames(len);
            check_rx($sformatf("mode%0d_rx", m), len);
        end
        read_check("rx_empty_read", RX_DATA_ADDR, 32'd0);

        // Overflow, every word carries last
        bus_write(CONTROL_ADDR, 32'd0);
        bus_write(CLK_DIV_ADDR, 32'(OVF_DIV));
        n_ok = accepted_writes(OVF_WRITES, WRITE_CLKS, 16 * (OVF_DIV + 1));
        for (int i = 0; i < OVF_WRITES; i++) begin
            r = next_rand();
            if (i < n_ok) sent_q.push_back(r[7:0]);
            bus_write(TX_DATA_ADDR, {23'd0, 1'b1, r[7:0]});
        end
        bus_read(STATUS_ADDR, st);
        check_eq("ovf_tx_full", 32'd1, 32'(st[3]));
        wait_idle();
        check_mosi("ovf_mosi", n_ok);
        frame_rd = frame_q.size();
        read_check("ovf_rx_full", STATUS_ADDR, (n_ok >= FIFO_DEPTH) ? 32'h6 : 32'h2);
        check_rx("ovf_rx", (n_ok < FIFO_DEPTH) ? n_ok : FIFO_DEPTH);
        miso_rd = miso_q.size();
        read_check("ovf_rx_drained", RX_DATA_ADDR, 32'd0);

        // Soft reset in the second word, with the first byte already received
        bus_write(CONTROL_ADDR, 32'd1);
        bus_write(CLK_DIV_ADDR, 32'(SR_DIV));
        for (int i = 0; i < SR_BYTES; i++) begin
            r = next_rand();
            bus_write(TX_DATA_ADDR, {23'd0, i == SR_BYTES - 1, r[7:0]});
        end
        repeat (200) @(negedge clk);
        read_check("soft_rst_pending", STATUS_ADDR, 32'h10);  // Busy, both FIFOs hold data
        bus_write(CONTROL_ADDR, 32'h4);
        read_check("soft_rst_status", STATUS_ADDR, 32'h3);
        check_eq("soft_rst_cs_n", 32'd1, 32'(spi.cs_n));
        read_check("soft_rst_control", CONTROL_ADDR, 32'd1);
        read_check("soft_rst_clk_div", CLK_DIV_ADDR, 32'(SR_DIV));
        mosi_rd  = mosi_q.size();
        miso_rd  = miso_q.size();
        frame_rd = frame_q.size();

        repeat (4) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors + slave_errors);
        if (errors + slave_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hw/spi_pkg.sv
hw/spi_fifo.sv
hw/spi_reg_file.sv
hw/spi_master.sv
hw/spi_ctrl_top.sv
tests/tb_spi_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the SPI controller testbench

VERILATOR  ?= verilator
TOP        ?= tb_spi_ctrl
RTL_TOP    ?= spi_ctrl_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= all tests passed

SOURCES := $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
